//--- rtl/cnn_layer_pkg.sv
`default_nettype none

package cnn_layer_pkg;

	// Image and output geometry.
	localparam int IMG_DIM = 32;
	localparam int OUT_DIM = 30;
	localparam int NUM_POSITIONS = OUT_DIM * OUT_DIM;

	// Kernel shape, 3x3 taps over three channels.
	localparam int KERNEL_TAPS = 9;
	localparam int NUM_FILTERS = 8;
	localparam int NUM_CHANNELS = 3;

	// Q8.8 fixed point.
	localparam int FRAC_BITS = 8;

	// Credits owned by the sender after reset, also the FIFO depth.
	localparam int RESULT_CREDITS = 4;

	typedef logic signed [15:0] chan_t;
	// Channel 0 sits in the low bits.
	typedef logic [NUM_CHANNELS*16-1:0] pixel_t;
	typedef logic [NUM_CHANNELS*16-1:0] weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic signed [39:0] acc_t;
	// Filter f in bits 16f up.
	typedef logic [NUM_FILTERS*16-1:0] feature_t;
	typedef logic [4:0] coord_t;

	typedef enum logic [1:0]
	{
		LOAD_PIXEL,
		LOAD_WEIGHT,
		LOAD_BIAS
	} load_kind_t;

	// One host load word.
	typedef struct packed
	{
		load_kind_t kind;
		logic [9:0] addr;
		pixel_t data;
	} load_word_t;

	// One output feature with its position.
	typedef struct packed
	{
		coord_t row;
		coord_t col;
		feature_t data;
	} result_t;

	typedef enum logic [1:0]
	{
		IDLE,
		RUN,
		DRAIN
	} seq_state_t;

endpackage

`default_nettype wire

//--- rtl/pixel_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module pixel_buffer
	import cnn_layer_pkg::*;
(
	input logic clk,
	input logic load_valid,
	input load_word_t load_word,
	input coord_t rd_row,
	input coord_t rd_col,
	output pixel_t rd_pixel
);

	// Image memory, row times 32 plus column.
	pixel_t img_mem [IMG_DIM*IMG_DIM];

	logic wr_en;
	logic [9:0] rd_addr;

	// Only pixel words land here.
	assign wr_en = load_valid && (load_word.kind == LOAD_PIXEL);

	// Row and column concatenate into the linear address.
	assign rd_addr = {rd_row, rd_col};

	// Load write port.
	always_ff @(posedge clk)
	begin
		if (wr_en)
			img_mem[load_word.addr] <= load_word.data;
	end

	// Registered read, one cycle after the address.
	always_ff @(posedge clk)
	begin
		rd_pixel <= img_mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- rtl/kernel_store.sv
`default_nettype none
`timescale 1ns/10ps

module kernel_store
	import cnn_layer_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic load_valid,
	input load_word_t load_word,
	input logic [3:0] rd_tap,
	output weight_t [NUM_FILTERS-1:0] rd_weights,
	output bias_t [NUM_FILTERS-1:0] biases
);

	// One bank per filter so a tap reads all eight at once.
	weight_t w_mem [NUM_FILTERS][KERNEL_TAPS];

	logic [2:0] wt_filter;
	logic [3:0] wt_tap;
	logic wt_ok;
	logic wt_wr;
	logic bias_wr;

	// Split filter times 9 plus tap.
	assign wt_filter = 3'(load_word.addr / 10'(KERNEL_TAPS));
	assign wt_tap = 4'(load_word.addr % 10'(KERNEL_TAPS));
	assign wt_ok = load_word.addr < 10'(NUM_FILTERS * KERNEL_TAPS);

	assign wt_wr = load_valid && (load_word.kind == LOAD_WEIGHT) && wt_ok;
	assign bias_wr = load_valid && (load_word.kind == LOAD_BIAS)
		&& (load_word.addr < 10'(NUM_FILTERS));

	// Weight write and the registered tap read.
	always_ff @(posedge clk)
	begin
		if (wt_wr)
			w_mem[wt_filter][wt_tap] <= load_word.data;
		for (int f = 0; f < NUM_FILTERS; f++)
			rd_weights[f] <= w_mem[f][rd_tap];
	end

	// Bias registers, held across frames.
	always_ff @(posedge clk)
	begin
		if (rst)
			biases <= '0;
		else if (bias_wr)
			biases[load_word.addr[2:0]] <= load_word.data[15:0];
	end

endmodule

`default_nettype wire

//--- rtl/conv_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

module conv_sequencer
	import cnn_layer_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic space_ok,
	input logic res_sent,
	output coord_t rd_row,
	output coord_t rd_col,
	output logic [3:0] rd_tap,
	output logic tap_valid,
	output logic first_tap,
	output logic last_tap,
	output coord_t pos_row,
	output coord_t pos_col,
	output logic started,
	output logic busy,
	output logic done
);

	seq_state_t state;
	logic [1:0] krow;
	logic [1:0] kcol;
	coord_t orow;
	coord_t ocol;
	logic [9:0] sent_cnt;
	logic at_first;
	logic at_last;
	logic last_col;
	logic last_pos;
	logic issue;

	assign at_first = (krow == 2'd0) && (kcol == 2'd0);
	assign at_last = (krow == 2'd2) && (kcol == 2'd2);
	assign last_col = (ocol == coord_t'(OUT_DIM - 1));
	assign last_pos = last_col && (orow == coord_t'(OUT_DIM - 1));

	// A new position waits for room downstream; inner taps never stall.
	assign issue = (state == RUN) && (!at_first || space_ok);
	assign started = issue && at_first;
	assign busy = (state != IDLE);

	// Read addresses are output position plus tap offset.
	assign rd_row = orow + coord_t'(krow);
	assign rd_col = ocol + coord_t'(kcol);
	assign rd_tap = 4'(krow) * 4'd3 + 4'(kcol);

	// Main FSM and position counters.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			krow <= '0;
			kcol <= '0;
			orow <= '0;
			ocol <= '0;
			sent_cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= RUN;
						krow <= '0;
						kcol <= '0;
						orow <= '0;
						ocol <= '0;
						sent_cnt <= '0;
					end
				end
				RUN:
				begin
					if (issue)
					begin
						// Kernel column, then kernel row.
						if (kcol == 2'd2)
						begin
							kcol <= '0;
							krow <= (krow == 2'd2) ? 2'd0 : krow + 2'd1;
						end
						else
							kcol <= kcol + 2'd1;
						// Step the output position after the ninth tap.
						if (at_last)
						begin
							if (last_col)
							begin
								ocol <= '0;
								orow <= orow + 5'd1;
							end
							else
								ocol <= ocol + 5'd1;
							if (last_pos)
								state <= DRAIN;
						end
					end
				end
				DRAIN:
				begin
					// Finish on the 900th word leaving.
					if (res_sent && (sent_cnt == 10'(NUM_POSITIONS - 1)))
					begin
						state <= IDLE;
						done <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
			if (res_sent)
				sent_cnt <= sent_cnt + 10'd1;
		end
	end

	// MAC controls, one cycle late to meet the memory read data.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tap_valid <= 1'b0;
			first_tap <= 1'b0;
			last_tap <= 1'b0;
		end
		else
		begin
			tap_valid <= issue;
			first_tap <= issue && at_first;
			last_tap <= issue && at_last;
		end
	end

	always_ff @(posedge clk)
	begin
		pos_row <= orow;
		pos_col <= ocol;
	end

endmodule

`default_nettype wire

//--- rtl/mac_array.sv
`default_nettype none
`timescale 1ns/10ps

module mac_array
	import cnn_layer_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic tap_valid,
	input logic first_tap,
	input logic last_tap,
	input coord_t pos_row,
	input coord_t pos_col,
	input pixel_t pixel,
	input weight_t [NUM_FILTERS-1:0] weights,
	input bias_t [NUM_FILTERS-1:0] biases,
	output logic res_valid,
	output result_t res_word
);

	acc_t tap_sum [NUM_FILTERS];
	acc_t acc_next [NUM_FILTERS];
	acc_t acc [NUM_FILTERS];
	// Second set, holds the finished sums during finalize.
	acc_t hold [NUM_FILTERS];
	coord_t hold_row;
	coord_t hold_col;

	// Per lane, the three channel products of this tap.
	always_comb
	begin
		chan_t px;
		chan_t wt;
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			tap_sum[f] = '0;
			for (int c = 0; c < NUM_CHANNELS; c++)
			begin
				px = pixel[16*c +: 16];
				wt = weights[f][16*c +: 16];
				tap_sum[f] = tap_sum[f] + acc_t'(px) * acc_t'(wt);
			end
			// First tap restarts the sum.
			acc_next[f] = (first_tap ? acc_t'(0) : acc[f]) + tap_sum[f];
		end
	end

	always_ff @(posedge clk)
	begin
		if (tap_valid)
		begin
			for (int f = 0; f < NUM_FILTERS; f++)
				acc[f] <= acc_next[f];
		end
		// Last tap hands over, so the next position can start.
		if (tap_valid && last_tap)
		begin
			for (int f = 0; f < NUM_FILTERS; f++)
				hold[f] <= acc_next[f];
			hold_row <= pos_row;
			hold_col <= pos_col;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			res_valid <= 1'b0;
		else
			res_valid <= tap_valid && last_tap;
	end

	// Bias, rescale to Q8.8, ReLU and clamp.
	always_comb
	begin
		acc_t sum;
		acc_t scaled;
		res_word.row = hold_row;
		res_word.col = hold_col;
		for (int f = 0; f < NUM_FILTERS; f++)
		begin
			sum = hold[f] + (acc_t'(biases[f]) <<< FRAC_BITS);
			scaled = sum >>> FRAC_BITS;
			if (scaled < 0)
				res_word.data[16*f +: 16] = 16'd0;
			else if (scaled > acc_t'(32767))
				res_word.data[16*f +: 16] = 16'h7fff;
			else
				res_word.data[16*f +: 16] = scaled[15:0];
		end
	end

endmodule

`default_nettype wire

//--- rtl/result_credit_tx.sv
`default_nettype none
`timescale 1ns/10ps

module result_credit_tx
	import cnn_layer_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic res_valid,
	input result_t res_word,
	input logic started,
	output logic space_ok,
	output logic res_sent,
	output logic out_valid,
	output result_t out_word,
	input logic credit_return
);

	result_t fifo_mem [RESULT_CREDITS];
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [2:0] fill;
	// Positions begun whose result has not reached the FIFO.
	logic [2:0] in_flight;
	logic [2:0] credits;
	logic pop;

	// Send only with a credit in hand and data queued.
	assign pop = (credits != 3'd0) && (fill != 3'd0);
	assign out_valid = pop;
	assign out_word = fifo_mem[rd_ptr];
	assign res_sent = pop;

	// Room for one more position, counting those still in the MAC.
	assign space_ok = (4'(fill) + 4'(in_flight)) < 4'(RESULT_CREDITS);

	always_ff @(posedge clk)
	begin
		if (res_valid)
			fifo_mem[wr_ptr] <= res_word;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			in_flight <= '0;
			credits <= 3'(RESULT_CREDITS);
		end
		else
		begin
			if (res_valid)
				wr_ptr <= wr_ptr + 2'd1;
			if (pop)
				rd_ptr <= rd_ptr + 2'd1;
			case ({res_valid, pop})
				2'b10: fill <= fill + 3'd1;
				2'b01: fill <= fill - 3'd1;
				default: fill <= fill;
			endcase
			case ({started, res_valid})
				2'b10: in_flight <= in_flight + 3'd1;
				2'b01: in_flight <= in_flight - 3'd1;
				default: in_flight <= in_flight;
			endcase
			// One credit back per return, one spent per word
			case ({credit_return, pop})
				2'b10: credits <= credits + 3'd1;
				2'b01: credits <= credits - 3'd1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/cnn_layer1_top.sv
`default_nettype none
`timescale 1ns/10ps

module cnn_layer1_top
	import cnn_layer_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic load_valid,
	input load_word_t load_word,
	input logic start,
	output logic out_valid,
	output result_t out_word,
	input logic credit_return,
	output logic busy,
	output logic done
);

	// Memory read side.
	coord_t rd_row;
	coord_t rd_col;
	logic [3:0] rd_tap;
	pixel_t rd_pixel;
	weight_t [NUM_FILTERS-1:0] rd_weights;
	bias_t [NUM_FILTERS-1:0] biases;

	// Sequencer to MAC.
	logic tap_valid;
	logic first_tap;
	logic last_tap;
	coord_t pos_row;
	coord_t pos_col;

	// MAC and sender handshakes.
	logic res_valid;
	result_t res_word;
	logic started;
	logic space_ok;
	logic res_sent;

	pixel_buffer u_pixel_buffer (
		.clk(clk),
		.load_valid(load_valid),
		.load_word(load_word),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.rd_pixel(rd_pixel)
	);

	kernel_store u_kernel_store (
		.clk(clk),
		.rst(rst),
		.load_valid(load_valid),
		.load_word(load_word),
		.rd_tap(rd_tap),
		.rd_weights(rd_weights),
		.biases(biases)
	);

	conv_sequencer u_conv_sequencer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.space_ok(space_ok),
		.res_sent(res_sent),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.rd_tap(rd_tap),
		.tap_valid(tap_valid),
		.first_tap(first_tap),
		.last_tap(last_tap),
		.pos_row(pos_row),
		.pos_col(pos_col),
		.started(started),
		.busy(busy),
		.done(done)
	);

	mac_array u_mac_array (
		.clk(clk),
		.rst(rst),
		.tap_valid(tap_valid),
		.first_tap(first_tap),
		.last_tap(last_tap),
		.pos_row(pos_row),
		.pos_col(pos_col),
		.pixel(rd_pixel),
		.weights(rd_weights),
		.biases(biases),
		.res_valid(res_valid),
		.res_word(res_word)
	);

	result_credit_tx u_result_credit_tx (
		.clk(clk),
		.rst(rst),
		.res_valid(res_valid),
		.res_word(res_word),
		.started(started),
		.space_ok(space_ok),
		.res_sent(res_sent),
		.out_valid(out_valid),
		.out_word(out_word),
		.credit_return(credit_return)
	);

endmodule

`default_nettype wire

//--- sim/cnn_ref_model.svh
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

// Expected feature word for one output position.
function automatic feature_t model_feature(int r, int c);
	feature_t res;
	longint acc;
	longint scaled;
	chan_t px;
	chan_t wt;
	res = '0;
	for (int f = 0; f < NUM_FILTERS; f++)
	begin
		acc = 0;
		for (int kr = 0; kr < 3; kr++)
			for (int kc = 0; kc < 3; kc++)
				for (int ch = 0; ch < NUM_CHANNELS; ch++)
				begin
					px = pix_mem[(r + kr) * IMG_DIM + (c + kc)][16*ch +: 16];
					wt = wt_mem[f * KERNEL_TAPS + kr * 3 + kc][16*ch +: 16];
					acc = acc + longint'(px) * longint'(wt);
				end
		// Bias moves to the product scale, Q16.16.
		acc = acc + longint'(bias_mem[f]) * (2 ** FRAC_BITS);
		// Floor back to Q8.8.
		scaled = acc >>> FRAC_BITS;
		if (scaled < 0)
			res[16*f +: 16] = 16'd0;
		else if (scaled > 32767)
			res[16*f +: 16] = 16'h7fff;
		else
			res[16*f +: 16] = scaled[15:0];
	end
	return res;
endfunction

// Whole 30x30 map in row-major order.
task automatic build_feature_map();
	for (int p = 0; p < NUM_POSITIONS; p++)
	begin
		exp_map[p].row = coord_t'(p / OUT_DIM);
		exp_map[p].col = coord_t'(p % OUT_DIM);
		exp_map[p].data = model_feature(p / OUT_DIM, p % OUT_DIM);
	end
endtask

// Lanes in the map that hold a given value.
function automatic int count_lanes(logic [15:0] value);
	int n;
	n = 0;
	for (int p = 0; p < NUM_POSITIONS; p++)
		for (int f = 0; f < NUM_FILTERS; f++)
			if (exp_map[p].data[16*f +: 16] == value)
				n++;
	return n;
endfunction

`endif

//--- sim/cnn_layer1_tb.sv
`default_nettype none
`timescale 1ns/10ps

module cnn_layer1_tb
	import cnn_layer_pkg::*;
();

	// Four frames of taps with slack, plus the loads.
	localparam int TIMEOUT_CYCLES = 4 * NUM_POSITIONS * KERNEL_TAPS * 3 + 3000;

	logic clk;
	logic rst;
	logic load_valid;
	load_word_t load_word;
	logic start;
	logic out_valid;
	result_t out_word;
	logic credit_return;
	logic busy;
	logic done;

	integer seed = 32'h49e;

	// Host copies of the loaded data.
	pixel_t pix_mem [IMG_DIM*IMG_DIM];
	weight_t wt_mem [NUM_FILTERS*KERNEL_TAPS];
	bias_t bias_mem [NUM_FILTERS];
	result_t exp_map [NUM_POSITIONS];

	int cycle = 0;
	// Cycle numbers at which credits go back.
	int due_q [$];
	int err_count = 0;
	int flag_errors = 0;
	int pass_tests = 0;
	int fail_tests = 0;
	int frame_rx = 0;
	int rx_total = 0;
	int ret_total = 0;
	int done_count = 0;
	int done_total = 0;
	// Clamped lanes seen on the output in the current frame.
	int sat_rx = 0;
	int zero_rx = 0;
	bit slow_credits = 1'b0;
	bit frame_active = 1'b0;
	bit done_seen = 1'b0;

	cnn_layer1_top u_dut (
		.clk(clk),
		.rst(rst),
		.load_valid(load_valid),
		.load_word(load_word),
		.start(start),
		.out_valid(out_valid),
		.out_word(out_word),
		.credit_return(credit_return),
		.busy(busy),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial
	begin
		while (cycle < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	function automatic int rand_below(int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	function automatic chan_t rand_chan(int span);
		return chan_t'($random(seed) % span);
	endfunction

	task automatic check_result(string name, result_t exp, result_t got);
		if (got !== exp)
		begin
			$display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
			err_count++;
		end
	endtask

	task automatic check_count(string name, int exp, int got);
		if (got != exp)
		begin
			$display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, got);
			err_count++;
		end
	endtask

	task automatic check_flag(string name, logic exp, logic got);
		if (got !== exp)
		begin
			$display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, got);
			err_count++;
			flag_errors++;
		end
	endtask

	task automatic report_test(string name, bit ok);
		if (ok)
			pass_tests++;
		else
			fail_tests++;
		$display("test %s: %s", name, ok ? "pass" : "fail");
	endtask

	// One load word per cycle, no handshake.
	task automatic write_load(load_kind_t kind, int addr, pixel_t data);
		load_word_t w;
		w.kind = kind;
		w.addr = 10'(addr);
		w.data = data;
		@(posedge clk);
		load_valid <= 1'b1;
		load_word <= w;
	endtask

	task automatic end_load();
		@(posedge clk);
		load_valid <= 1'b0;
	endtask

	task automatic load_random_image();
		for (int i = 0; i < IMG_DIM * IMG_DIM; i++)
		begin
			pix_mem[i] = {rand_chan(512), rand_chan(512), rand_chan(512)};
			write_load(LOAD_PIXEL, i, pix_mem[i]);
		end
		end_load();
	endtask

	task automatic load_random_weights();
		for (int i = 0; i < NUM_FILTERS * KERNEL_TAPS; i++)
		begin
			wt_mem[i] = {rand_chan(256), rand_chan(256), rand_chan(256)};
			write_load(LOAD_WEIGHT, i, wt_mem[i]);
		end
		end_load();
	endtask

	task automatic load_bias(int f, bias_t b);
		bias_mem[f] = b;
		write_load(LOAD_BIAS, f, pixel_t'({32'd0, b}));
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Start a frame and wait for done, optionally poking start mid-frame.
	task automatic run_frame(bit slow, bit extra_start);
		slow_credits = slow;
		frame_rx = 0;
		done_count = 0;
		sat_rx = 0;
		zero_rx = 0;
		done_seen = 1'b0;
		pulse_start();
		frame_active = 1'b1;
		if (extra_start)
		begin
			while (frame_rx < NUM_POSITIONS / 3)
				@(posedge clk);
			pulse_start();
		end
		while (!done_seen)
			@(posedge clk);
		// Window to catch stray words or a second done.
		repeat (40)
			@(posedge clk);
		@(negedge clk);
		check_count("result_words", NUM_POSITIONS, frame_rx);
		check_count("done_pulses", 1, done_count);
		check_flag("busy", 1'b0, busy);
		slow_credits = 1'b0;
	endtask

	// Receiver, scoreboard and flag monitor on settled outputs.
	always @(negedge clk)
	begin : rx_monitor
		int outstanding;
		if (!rst)
		begin
			outstanding = rx_total - ret_total;
			if (outstanding == RESULT_CREDITS)
				check_flag("out_valid", 1'b0, out_valid);
			if (done)
			begin
				if (!frame_active)
				begin
					$display("ERROR: t=%0t done pulsed while no frame was running", $time);
					err_count++;
					flag_errors++;
				end
				check_count("words_before_done", NUM_POSITIONS, frame_rx);
				done_count++;
				done_total++;
				done_seen = 1'b1;
				frame_active = 1'b0;
			end
			else if (frame_active)
				check_flag("busy", 1'b1, busy);
			if (out_valid)
			begin
				if (frame_rx < NUM_POSITIONS)
					check_result("out_word", exp_map[frame_rx], out_word);
				else
				begin
					$display("ERROR: t=%0t result word arrived after the last one", $time);
					err_count++;
				end
				for (int f = 0; f < NUM_FILTERS; f++)
				begin
					if (out_word.data[16*f +: 16] == 16'h7fff)
						sat_rx++;
					if (out_word.data[16*f +: 16] == 16'h0000)
						zero_rx++;
				end
				frame_rx++;
				rx_total++;
				due_q.push_back(cycle + (slow_credits ? 10 + rand_below(51) : rand_below(7)));
			end
			if (credit_return)
				ret_total++;
			if (rx_total - ret_total > RESULT_CREDITS)
				check_count("credits_outstanding", RESULT_CREDITS, rx_total - ret_total);
		end
	end

	// At most one credit back per cycle, oldest first.
	always @(posedge clk)
	begin : credit_driver
		if (rst)
			credit_return <= 1'b0;
		else if (due_q.size() != 0 && due_q[0] <= cycle)
		begin
			void'(due_q.pop_front());
			credit_return <= 1'b1;
		end
		else
			credit_return <= 1'b0;
	end

	initial
	begin : main_seq
		int errs;
		rst = 1'b1;
		load_valid = 1'b0;
		load_word = '0;
		start = 1'b0;
		credit_return = 1'b0;
		repeat (10)
			@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);

		// Random small data.
		errs = err_count;
		load_random_image();
		load_random_weights();
		for (int f = 0; f < NUM_FILTERS; f++)
			load_bias(f, bias_t'(rand_chan(512)));
		end_load();
		build_feature_map();
		run_frame(1'b0, 1'b0);
		report_test("random_frame", err_count == errs);

		// Same data, slow credit return.
		errs = err_count;
		run_frame(1'b1, 1'b0);
		report_test("back_pressure", err_count == errs);

		// Big weights on filters 0 to 3, negative biases on 4 to 7.
		errs = err_count;
		for (int i = 0; i < 4 * KERNEL_TAPS; i++)
		begin
			wt_mem[i] = {3{16'h7000}};
			write_load(LOAD_WEIGHT, i, wt_mem[i]);
		end
		for (int f = 0; f < NUM_FILTERS; f++)
			load_bias(f, (f < 4) ? bias_t'(rand_chan(512)) : bias_t'(16'hc000));
		end_load();
		build_feature_map();
		run_frame(1'b0, 1'b0);
		check_count("saturated_lanes", count_lanes(16'h7fff), sat_rx);
		check_count("zero_lanes", count_lanes(16'h0000), zero_rx);
		report_test("relu_saturation", err_count == errs);

		// New biases only, with a start pulse during busy.
		errs = err_count;
		for (int f = 0; f < NUM_FILTERS; f++)
			load_bias(f, bias_t'(rand_chan(512)));
		end_load();
		build_feature_map();
		run_frame(1'b0, 1'b1);
		report_test("persistence", err_count == errs);

		// Busy and done over all frames.
		errs = err_count;
		check_count("done_pulses_total", 4, done_total);
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		report_test("control_flags", (err_count == errs) && (flag_errors == 0));

		$display("tests passed %0d failed %0d, mismatches %0d", pass_tests, fail_tests,
			err_count);
		if ((fail_tests == 0) && (err_count == 0))
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	`include "cnn_ref_model.svh"

endmodule

`default_nettype wire

//--- compile.f
+incdir+sim
rtl/cnn_layer_pkg.sv
rtl/pixel_buffer.sv
rtl/kernel_store.sv
rtl/conv_sequencer.sv
rtl/mac_array.sv
rtl/result_credit_tx.sv
rtl/cnn_layer1_top.sv
sim/cnn_layer1_tb.sv
